//--- src/cpuDefines_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and address width
`define CPU_WORD 32

// Unified memory size in words
`define CPU_MEM_DEPTH 1024

// First fetch address once halt is released
`define CPU_RESET_VECTOR 0

// An all-ones instruction word stops the core
`define CPU_ILLEGAL_INSN {`CPU_WORD{1'b1}}

`endif

//--- src/cpuPkg.sv
`include "cpuDefines_defines.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        aluOr     = 4'h0,  // X | Y
        aluAnd    = 4'h1,  // X & Y
        aluAdd    = 4'h2,  // X + Y
        aluMul    = 4'h3,  // X * Y
        aluRsvd4  = 4'h4,
        aluShl    = 4'h5,  // X << Y
        aluLt     = 4'h6,  // Signed X < Y
        aluEq     = 4'h7,  // X == Y
        aluGt     = 4'h8,  // Signed X > Y
        aluAndNot = 4'h9,  // X & ~Y
        aluXor    = 4'hA,  // X ^ Y
        aluSub    = 4'hB,  // X - Y
        aluXnor   = 4'hC,  // X ^ ~Y
        aluShr    = 4'hD,  // Logical X >> Y
        aluNe     = 4'hE,  // X != Y
        aluRsvd15 = 4'hF
    } aluOp_e;

    // Z op= X op Y + imm, packed MSB first
    typedef struct packed {
        logic               spare;
        logic               kind;      // Swaps Y and imm roles
        logic               storing;
        logic               derefRhs;
        logic [3:0]         z;
        logic [3:0]         x;
        logic [3:0]         y;
        aluOp_e             op;
        logic signed [11:0] imm;
    } insn_t;

    typedef struct packed {
        logic                 valid;   // Single-cycle strobe
        logic                 write;
        logic [`CPU_WORD-1:0] addr;    // Word address
        logic [`CPU_WORD-1:0] wrData;
    } memReq_t;

    typedef struct packed {
        logic                 valid;   // One cycle after a read strobe
        logic [`CPU_WORD-1:0] rdData;
    } memRsp_t;

endpackage

//--- src/regFile.sv
`include "cpuDefines_defines.svh"

module regFile (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [3:0]           xIdx,
    input  logic [3:0]           yIdx,
    input  logic [3:0]           zIdx,
    input  logic [`CPU_WORD-1:0] nextPc,
    input  logic                 wrEn,
    input  logic [`CPU_WORD-1:0] wrData,
    output logic [`CPU_WORD-1:0] xVal,
    output logic [`CPU_WORD-1:0] yVal,
    output logic [`CPU_WORD-1:0] zVal
);

    logic [`CPU_WORD-1:0] regs [1:14];  // r0 and r15 are not stored

    // r0 is hardwired zero, r15 shows the next instruction address
    function automatic logic [`CPU_WORD-1:0] readPort(input logic [3:0] idx);
        logic [`CPU_WORD-1:0] val;
        if (idx == 4'd0) begin
            val = '0;
        end else if (idx == 4'd15) begin
            val = nextPc;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    assign xVal = readPort(xIdx);
    assign yVal = readPort(yIdx);
    assign zVal = readPort(zIdx);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && zIdx != 4'd0 && zIdx != 4'd15) begin
            regs[zIdx] <= wrData;  // PC updates happen in the core
        end
    end

endmodule

//--- src/insnDecode.sv
`include "cpuDefines_defines.svh"

module insnDecode (
    input  cpuPkg::insn_t insn,
    output logic          illegal,
    output logic          storing,
    output logic          derefRhs,
    output logic          kind,
    output logic          branch
);

    logic zIsPc;

    // Whole word compare, the spare bit included
    assign illegal = insn == `CPU_ILLEGAL_INSN;

    assign storing  = insn.storing;
    assign derefRhs = insn.derefRhs;
    assign kind     = insn.kind;

    assign zIsPc  = insn.z == 4'd15;
    assign branch = zIsPc && !insn.storing;  // Writes to r15 redirect fetch

endmodule

//--- src/execUnit.sv
`include "cpuDefines_defines.svh"

module execUnit (
    input  logic                 clk,
    input  logic                 en,
    input  cpuPkg::aluOp_e       op,
    input  logic                 kind,
    input  logic [`CPU_WORD-1:0] xVal,
    input  logic [`CPU_WORD-1:0] yVal,
    input  logic [11:0]          imm,
    output logic [`CPU_WORD-1:0] rhs
);
    import cpuPkg::*;

    logic signed [`CPU_WORD-1:0] extImm;
    logic signed [`CPU_WORD-1:0] opX;
    logic signed [`CPU_WORD-1:0] opO;    // Right operand of op
    logic signed [`CPU_WORD-1:0] opA;    // Added last
    logic        [`CPU_WORD-1:0] opResult;
    logic                        reserved;

    assign extImm = {{(`CPU_WORD - 12){imm[11]}}, imm};
    assign opX    = xVal;

    // kind 0 is X op Y + imm, kind 1 is X op imm + Y
    assign opO = kind ? extImm : yVal;
    assign opA = kind ? yVal : extImm;

    assign reserved = (op == aluRsvd4) || (op == aluRsvd15);

    always_comb begin
        case (op)
            aluOr:     opResult = opX | opO;
            aluAnd:    opResult = opX & opO;
            aluAdd:    opResult = opX + opO;
            aluMul:    opResult = opX * opO;
            aluShl:    opResult = opX << opO;
            aluLt:     opResult = {`CPU_WORD{opX < opO}};  // All ones when true
            aluEq:     opResult = {`CPU_WORD{opX == opO}};
            aluGt:     opResult = {`CPU_WORD{opX > opO}};
            aluAndNot: opResult = opX & ~opO;
            aluXor:    opResult = opX ^ opO;
            aluSub:    opResult = opX - opO;
            aluXnor:   opResult = opX ^ ~opO;
            aluShr:    opResult = opX >> opO;
            aluNe:     opResult = {`CPU_WORD{opX != opO}};
            default:   opResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rhs <= reserved ? '0 : opResult + opA;  // Reserved ops give zero
        end
    end

endmodule

//--- src/cpuCore.sv
`include "cpuDefines_defines.svh"

module cpuCore (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            haltReq,
    output logic            halted,
    output cpuPkg::memReq_t fetchReq,
    input  cpuPkg::memRsp_t fetchRsp,
    output cpuPkg::memReq_t dataReq,
    input  cpuPkg::memRsp_t dataRsp
);
    import cpuPkg::*;

    typedef enum logic [2:0] {
        stIdle, stFetch, stDecode, stExecute, stAccess, stCapture, stCommit, stStopped
    } state_e;

    state_e               state;
    logic [`CPU_WORD-1:0] pc;
    logic [`CPU_WORD-1:0] nextPc;
    insn_t                insnReg;      // Held for the later states
    insn_t                curInsn;
    logic [`CPU_WORD-1:0] loadData;
    logic                 illegal;
    logic                 storing;
    logic                 derefRhs;
    logic                 kind;
    logic                 branch;
    logic                 loading;
    logic                 exEn;
    logic                 wrEn;
    logic [`CPU_WORD-1:0] commitData;
    logic [`CPU_WORD-1:0] xVal;
    logic [`CPU_WORD-1:0] yVal;
    logic [`CPU_WORD-1:0] zVal;
    logic [`CPU_WORD-1:0] rhs;

    // Fetched word is used straight off the response in Decode
    assign curInsn = (state == stDecode) ? insn_t'(fetchRsp.rdData) : insnReg;

    assign nextPc     = pc + `CPU_WORD'(1);
    assign halted     = (state == stIdle) || (state == stStopped);
    assign exEn       = (state == stDecode) && !illegal;
    assign loading    = derefRhs && !storing;
    assign wrEn       = (state == stCommit) && !storing;
    assign commitData = loading ? loadData : rhs;

    insnDecode decode (
        .insn     (curInsn),
        .illegal  (illegal),
        .storing  (storing),
        .derefRhs (derefRhs),
        .kind     (kind),
        .branch   (branch)
    );

    regFile regs (
        .clk     (clk),
        .reset_n (reset_n),
        .xIdx    (curInsn.x),
        .yIdx    (curInsn.y),
        .zIdx    (curInsn.z),
        .nextPc  (nextPc),
        .wrEn    (wrEn),
        .wrData  (commitData),
        .xVal    (xVal),
        .yVal    (yVal),
        .zVal    (zVal)
    );

    execUnit exec (
        .clk  (clk),
        .en   (exEn),
        .op   (curInsn.op),
        .kind (kind),
        .xVal (xVal),
        .yVal (yVal),
        .imm  (curInsn.imm),
        .rhs  (rhs)
    );

    assign fetchReq = '{valid: state == stFetch, write: 1'b0, addr: pc, wrData: '0};

    always_comb begin
        dataReq       = '0;
        dataReq.valid = (state == stAccess) && (loading || storing);
        dataReq.write = storing;
        if (storing && !derefRhs) begin
            dataReq.addr   = zVal;     // [Z] <- rhs
            dataReq.wrData = rhs;
        end else begin
            dataReq.addr   = rhs;      // Load, or [rhs] <- Z
            dataReq.wrData = zVal;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= stIdle;
            pc    <= `CPU_WORD'(`CPU_RESET_VECTOR);
        end else begin
            case (state)
                stIdle: begin
                    pc <= `CPU_WORD'(`CPU_RESET_VECTOR);
                    if (!haltReq) begin
                        state <= stFetch;
                    end
                end
                stFetch:   state <= stDecode;
                stDecode:  state <= illegal ? stStopped : stExecute;
                stExecute: state <= stAccess;
                stAccess:  state <= stCapture;
                stCapture: state <= stCommit;
                stCommit: begin
                    pc    <= branch ? commitData : nextPc;
                    state <= haltReq ? stIdle : stFetch;  // Halt only between insns
                end
                stStopped: begin
                    if (haltReq) begin
                        state <= stIdle;
                    end
                end
                default:   state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stDecode) begin
            insnReg <= fetchRsp.rdData;
        end
        if (state == stCapture && dataRsp.valid) begin
            loadData <= dataRsp.rdData;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        !(fetchReq.valid && dataReq.valid))
        else $error("cpuCore: fetch and data strobes in the same cycle");

    // Arbiter and memory must return the word exactly one cycle after Fetch
    assert property (@(posedge clk) disable iff (!reset_n)
        state == stDecode |-> fetchRsp.valid)
        else $error("cpuCore: no fetch response in Decode");

endmodule

//--- src/memArbiter.sv
module memArbiter (
    input  logic            clk,
    input  logic            reset_n,
    input  cpuPkg::memReq_t extReq,
    input  cpuPkg::memReq_t dataReq,
    input  cpuPkg::memReq_t fetchReq,
    output cpuPkg::memRsp_t extRsp,
    output cpuPkg::memRsp_t dataRsp,
    output cpuPkg::memRsp_t fetchRsp,
    output cpuPkg::memReq_t memReq,
    input  cpuPkg::memRsp_t memRsp
);

    typedef enum logic [1:0] {ownNone, ownExt, ownData, ownFetch} owner_e;

    owner_e grant;
    owner_e owner;    // Who gets next cycle's read data

    // Priority is external, then data, then fetch
    always_comb begin
        grant  = ownNone;
        memReq = '0;
        if (extReq.valid) begin
            grant  = ownExt;
            memReq = extReq;
        end else if (dataReq.valid) begin
            grant  = ownData;
            memReq = dataReq;
        end else if (fetchReq.valid) begin
            grant  = ownFetch;
            memReq = fetchReq;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            owner <= ownNone;
        end else if (memReq.valid && !memReq.write) begin
            owner <= grant;
        end else begin
            owner <= ownNone;  // Writes get no response
        end
    end

    assign extRsp   = '{valid: memRsp.valid && owner == ownExt,   rdData: memRsp.rdData};
    assign dataRsp  = '{valid: memRsp.valid && owner == ownData,  rdData: memRsp.rdData};
    assign fetchRsp = '{valid: memRsp.valid && owner == ownFetch, rdData: memRsp.rdData};

    // A losing request would be silently dropped
    assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({extReq.valid, dataReq.valid, fetchReq.valid}))
        else $error("memArbiter: colliding requests");

endmodule

//--- src/unifiedMem.sv
`include "cpuDefines_defines.svh"

module unifiedMem (
    input  logic            clk,
    input  cpuPkg::memReq_t req,
    output cpuPkg::memRsp_t rsp
);

    localparam int AddrBits = $clog2(`CPU_MEM_DEPTH);

    logic [`CPU_WORD-1:0] words [0:`CPU_MEM_DEPTH-1];
    logic [AddrBits-1:0]  wordAddr;
    logic                 rdStrobe;
    logic                 wrStrobe;

    assign wordAddr = req.addr[AddrBits-1:0];
    assign rdStrobe = req.valid && !req.write;
    assign wrStrobe = req.valid && req.write;

    always_ff @(posedge clk) begin
        if (wrStrobe) begin
            words[wordAddr] <= req.wrData;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rsp.valid <= rdStrobe;
        if (rdStrobe) begin
            rsp.rdData <= words[wordAddr];
        end
    end

    assert property (@(posedge clk) req.valid |-> req.addr < `CPU_MEM_DEPTH)
        else $error("unifiedMem: address %0h beyond depth", req.addr);

endmodule

//--- src/cpuTop.sv
module cpuTop (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            haltReq,
    output logic            halted,
    input  cpuPkg::memReq_t extReq,
    output cpuPkg::memRsp_t extRsp
);
    import cpuPkg::*;

    memReq_t fetchReq;
    memRsp_t fetchRsp;
    memReq_t dataReq;
    memRsp_t dataRsp;
    memReq_t memReq;    // Granted request
    memRsp_t memRsp;

    cpuCore core (
        .clk      (clk),
        .reset_n  (reset_n),
        .haltReq  (haltReq),
        .halted   (halted),
        .fetchReq (fetchReq),
        .fetchRsp (fetchRsp),
        .dataReq  (dataReq),
        .dataRsp  (dataRsp)
    );

    memArbiter arb (
        .clk      (clk),
        .reset_n  (reset_n),
        .extReq   (extReq),
        .dataReq  (dataReq),
        .fetchReq (fetchReq),
        .extRsp   (extRsp),
        .dataRsp  (dataRsp),
        .fetchRsp (fetchRsp),
        .memReq   (memReq),
        .memRsp   (memRsp)
    );

    unifiedMem mem (
        .clk (clk),
        .req (memReq),
        .rsp (memRsp)
    );

endmodule

//--- tb/cpuTopTb.sv
`include "cpuDefines_defines.svh"

module cpuTopTb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpuPkg::*;

    logic    clk;
    logic    reset_n;
    logic    haltReq;
    logic    halted;
    memReq_t extReq;
    memRsp_t extRsp;

    logic [7:0]           recKind [$];  // L, R or E
    logic [`CPU_WORD-1:0] recA [$];
    logic [`CPU_WORD-1:0] recB [$];
    int                   watchCycles = 0;
    int                   passCount = 0;
    int                   failCount = 0;
    int                   runIdx = 0;
    bit                   traceOk;

    cpuTop DUT (
        .clk     (clk),
        .reset_n (reset_n),
        .haltReq (haltReq),
        .halted  (halted),
        .extReq  (extReq),
        .extRsp  (extRsp)
    );

    always #5 clk = ~clk;

    task automatic readTrace(output bit ok);
        int                   fd;
        string                line;
        logic [7:0]           k;
        logic [`CPU_WORD-1:0] a;
        logic [`CPU_WORD-1:0] b;
        int                   budget;
        ok = 0;
        budget = 30;  // Reset and final settling
        fd = $fopen("tb/cpuTrace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file tb/cpuTrace.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                a = '0;
                b = '0;
                void'($sscanf(line, "%c %h %h", k, a, b));
                budget += (k == "R") ? 6 * int'(a) + 30 : 4;
                recKind.push_back(k);
                recA.push_back(a);
                recB.push_back(b);
            end
        end
        $fclose(fd);
        watchCycles = budget;
        ok = recKind.size() > 0;
    endtask

    task automatic writeWord(input logic [`CPU_WORD-1:0] addr, input logic [`CPU_WORD-1:0] data);
        @(negedge clk);
        extReq = '{valid: 1'b1, write: 1'b1, addr: addr, wrData: data};
        @(negedge clk);
        extReq = '0;
    endtask

    task automatic checkWord(input logic [`CPU_WORD-1:0] addr,
                             input logic [`CPU_WORD-1:0] expWord);
        int                   waited;
        bit                   got;
        logic [`CPU_WORD-1:0] data;
        waited = 0;
        got = 0;
        data = '0;
        @(negedge clk);
        extReq = '{valid: 1'b1, write: 1'b0, addr: addr, wrData: '0};
        while (!got && waited < 4) begin
            @(negedge clk);
            extReq = '0;
            waited++;
            if (extRsp.valid) begin
                got = 1;
                data = extRsp.rdData;
            end
        end
        assert (got) else begin
            $display("No read response for address %h on the external port", addr);
            failCount++;
        end
        if (got) begin
            assert (data === expWord) begin
                $display("Read %h: %h ok", addr, data);
                passCount++;
            end else begin
                $display("Error at %0t: extRsp.rdData @%h expected %h actual %h",
                         $time, addr, expWord, data);
                failCount++;
            end
        end
    endtask

    // Release halt, then wait for the core to stop on its illegal word
    task automatic runProgram(input int count);
        int waited;
        bit started;
        runIdx++;
        waited = 0;
        @(negedge clk);
        haltReq = 1'b0;
        while (halted && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        started = !halted;
        waited = 0;
        while (!halted && waited < 6 * count + 20) begin
            @(negedge clk);
            waited++;
        end
        assert (started && halted) begin
            $display("Run %0d: halted after %0d cycles", runIdx, waited);
            passCount++;
        end else begin
            $display("Run %0d: core did not start and halt within %0d cycles",
                     runIdx, 6 * count + 20);
            failCount++;
        end
        haltReq = 1'b1;
        repeat (2) @(negedge clk);  // Stopped back to Idle
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        haltReq = 1'b1;
        extReq = '0;
        readTrace(traceOk);
        if (traceOk) begin
            repeat (16) @(negedge clk);
            reset_n = 1'b1;
            for (int i = 0; i < recKind.size(); i++) begin
                case (recKind[i])
                    "L": writeWord(recA[i], recB[i]);
                    "R": runProgram(int'(recA[i]));
                    "E": checkWord(recA[i], recB[i]);
                    default: begin
                        $display("Unknown trace record kind at entry %0d", i);
                        failCount++;
                    end
                endcase
            end
        end else begin
            failCount++;
        end
        $display("Checks: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Budget comes from the trace, so start only once it is read
    initial begin
        wait (watchCycles != 0);
        repeat (watchCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", watchCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb/cpuTrace.txt
# L addr data = external write, R count = run at most count insns, E addr data = read and compare
# Program 1 covers every opcode, r0/r15, load, both stores, branch, loop and the illegal stop
L 00000000 01002064
L 00000001 02002FFD
L 00000002 03123005
L 00000003 33002100
L 00000004 0412A000
L 00000005 04410010
L 00000006 44411007
L 00000007 34002101
L 00000008 05219000
L 00000009 0551C000
L 0000000A 05155FFF
L 0000000B 4552D004
L 0000000C 0551B200
L 0000000D 35002102
L 0000000E 4620D01C
L 0000000F 07216010
L 00000010 08677020
L 00000011 49288005
L 00000012 4A99E064
L 00000013 0B128080
L 00000014 0CBA2000
L 00000015 3C002103
L 00000016 00102000
L 00000017 30002104
L 00000018 3F002105
L 00000019 1D1020BC
L 0000001A 2CD02001
L 0000001B 0FF02002
L 0000001C 31002106
L 0000001D 31002107
L 0000001E 0E002005
L 0000001F 06000000
L 00000020 06602003
L 00000021 0EE02FFF
L 00000022 09E0E000
L 00000023 4F9F1FFC
L 00000024 36002108
L 00000025 FFFFFFFF
L 00000120 CAFE1234
L 00000106 11111111
L 00000107 22222222
R 00000060
E 00000100 FFFFFED9
E 00000101 00000069
E 00000102 000001B1
E 00000103 0000009D
E 00000104 00000000
E 00000105 00000019
E 0000009D CAFE1235
E 00000106 11111111
E 00000107 22222222
E 00000108 0000000F
# Program 2 reloads the reset vector
L 00000000 010027FF
L 00000001 42103FFE
L 00000002 32002110
L 00000003 FFFFFFFF
R 0000000A
E 00000110 FFFFF002
E 00000108 0000000F

//--- vlog.f
+incdir+src
src/cpuPkg.sv
src/regFile.sv
src/insnDecode.sv
src/execUnit.sv
src/cpuCore.sv
src/memArbiter.sv
src/unifiedMem.sv
src/cpuTop.sv
tb/cpuTopTb.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module cpuTopTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
